// ==== Makefile ====
TOOL   = verilator
FLAGS  = --binary --timing --assert -j 0
TOP    = rps_tb
FLIST  = src.f
OBJDIR = obj_dir
LOG    = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(OBJDIR)

run: compile
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "Test completed successfully" $(LOG) || (echo "simulation reported failure"; exit 1)

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== logic/key_capture.sv ====
`timescale 1ns/1ps

module key_capture (
  input  logic            clk,
  input  logic            DELAY,
  input  logic [2:0]      keys,
  output rps_pkg::round_t round,
  output logic            held
);

  logic [2:0]       keys_q;
  logic             new_press;
  rps_pkg::choice_t key_choice;
  rps_pkg::choice_t com_pick;

  assign held      = |keys;
  assign new_press = $onehot(keys) && (keys_q == 3'b000);  // rising, single key only

  always_comb begin
    case (keys)
      3'b001:  key_choice = rps_pkg::rock;
      3'b010:  key_choice = rps_pkg::scissors;
      3'b100:  key_choice = rps_pkg::paper;
      default: key_choice = rps_pkg::none;
    endcase
  end

  always_ff @(posedge clk or posedge DELAY) begin
    if (DELAY) begin
      keys_q   <= 3'b000;
      com_pick <= rps_pkg::rock;
      round    <= '0;
    end else begin
      keys_q      <= keys;
      round.start <= new_press;
      if (keys == 3'b000) begin  // spins only while idle
        case (com_pick)
          rps_pkg::rock:     com_pick <= rps_pkg::scissors;
          rps_pkg::scissors: com_pick <= rps_pkg::paper;
          default:           com_pick <= rps_pkg::rock;
        endcase
      end
      if (new_press) begin
        round.user <= key_choice;
        round.com  <= com_pick;
      end
    end
  end

endmodule

// ==== logic/matrix_scan.sv ====
`timescale 1ns/1ps

module matrix_scan #(
  parameter int SCAN_DIV = 9000
) (
  input  logic                          clk,
  input  logic                          DELAY,
  input  rps_pkg::screen_t              screen,
  input  rps_pkg::score_t               score,
  output logic [rps_pkg::NUM_COLS-1:0]  dot_col,
  output logic [rps_pkg::ROW_BITS-1:0]  dot_row,
  output logic [rps_pkg::LED_BITS-1:0]  user_leds,
  output logic [rps_pkg::LED_BITS-1:0]  com_leds
);

  localparam int DW = $clog2(SCAN_DIV + 1);
  localparam int IW = $clog2(rps_pkg::NUM_COLS);
  localparam logic [rps_pkg::NUM_COLS-1:0] COL0 = 1;

  logic [DW-1:0] div_cnt;
  logic [IW-1:0] col_idx;
  logic          col_step;

  // bar grows from the msb end
  function automatic logic [rps_pkg::LED_BITS-1:0] thermo(logic [2:0] n);
    logic [rps_pkg::LED_BITS-1:0] bar;
    bar = '0;
    for (int i = 0; i < rps_pkg::LED_BITS; i++) begin
      bar[rps_pkg::LED_BITS-1-i] = (i < int'(n));
    end
    return bar;
  endfunction

  assign col_step = (div_cnt == DW'(SCAN_DIV - 1));

  always_ff @(posedge clk or posedge DELAY) begin
    if (DELAY) begin
      div_cnt <= '0;
      col_idx <= '0;
    end else if (col_step) begin
      div_cnt <= '0;
      if (col_idx == IW'(rps_pkg::NUM_COLS - 1))
        col_idx <= '0;
      else
        col_idx <= col_idx + IW'(1);
    end else begin
      div_cnt <= div_cnt + DW'(1);
    end
  end

  assign dot_col = COL0 << col_idx;

  always_comb begin
    case (screen)
      rps_pkg::scr_rock:     dot_row = rps_pkg::glyph_rows[0][col_idx];
      rps_pkg::scr_scissors: dot_row = rps_pkg::glyph_rows[1][col_idx];
      rps_pkg::scr_paper:    dot_row = rps_pkg::glyph_rows[2][col_idx];
      default:               dot_row = '0;  // result and verdict stay dark
    endcase
  end

  assign user_leds = thermo(score.user_wins);
  assign com_leds  = thermo(score.com_wins);

endmodule

// ==== logic/round_sequencer.sv ====
`timescale 1ns/1ps

module round_sequencer #(
  parameter int TICK_DIV   = 12500000,
  parameter int WIN_TARGET = 3
) (
  input  logic              clk,
  input  logic              DELAY,
  input  rps_pkg::round_t   round,
  input  logic              held,
  output rps_pkg::phase_t   phase,
  output rps_pkg::outcome_t outcome,
  output rps_pkg::screen_t  screen,
  output rps_pkg::score_t   score
);

  localparam int CW = $clog2(TICK_DIV + 1);
  localparam int TW = $clog2(rps_pkg::FINAL_TICK + 1);

  logic [CW-1:0]     cycle_cnt;
  logic [TW-1:0]     tick_cnt;
  logic [TW-1:0]     tick_next;
  logic              timing;
  logic              tick_wrap;
  rps_pkg::outcome_t judged;
  rps_pkg::phase_t   phase_d;
  rps_pkg::screen_t  screen_d;

  function automatic rps_pkg::outcome_t judge(rps_pkg::choice_t user, rps_pkg::choice_t com);
    if (user == com)
      return rps_pkg::draw;
    if ((user == rps_pkg::rock && com == rps_pkg::scissors) ||
        (user == rps_pkg::scissors && com == rps_pkg::paper) ||
        (user == rps_pkg::paper && com == rps_pkg::rock))
      return rps_pkg::win;
    return rps_pkg::lose;
  endfunction

  assign judged    = judge(round.user, round.com);
  assign timing    = (phase == rps_pkg::show_choice) || (phase == rps_pkg::show_result);
  assign tick_wrap = timing && (cycle_cnt == CW'(TICK_DIV - 1));
  assign tick_next = tick_cnt + TW'(1);

  always_comb begin
    phase_d = phase;
    if (round.start) begin
      phase_d = rps_pkg::show_choice;
    end else if (!held) begin
      phase_d = rps_pkg::idle;
    end else if (tick_wrap) begin
      if (tick_next == TW'(rps_pkg::CHOICE_TICKS))
        phase_d = rps_pkg::show_result;
      else if (tick_next == TW'(rps_pkg::FINAL_TICK))
        phase_d = rps_pkg::show_final;
    end
  end

  always_comb begin
    screen_d = rps_pkg::scr_blank;
    case (phase_d)
      rps_pkg::show_choice: begin
        case (round.com)
          rps_pkg::rock:     screen_d = rps_pkg::scr_rock;
          rps_pkg::scissors: screen_d = rps_pkg::scr_scissors;
          rps_pkg::paper:    screen_d = rps_pkg::scr_paper;
          default:           screen_d = rps_pkg::scr_blank;
        endcase
      end
      rps_pkg::show_result: begin
        case (outcome)  // settled since the start edge
          rps_pkg::win:  screen_d = rps_pkg::scr_win;
          rps_pkg::lose: screen_d = rps_pkg::scr_lose;
          default:       screen_d = rps_pkg::scr_draw;
        endcase
      end
      rps_pkg::show_final: begin
        if (score.com_wins >= 3'(WIN_TARGET))  // computer first
          screen_d = rps_pkg::scr_sad;
        else if (score.user_wins >= 3'(WIN_TARGET))
          screen_d = rps_pkg::scr_happy;
      end
      default: screen_d = rps_pkg::scr_blank;
    endcase
  end

  always_ff @(posedge clk or posedge DELAY) begin
    if (DELAY) begin
      phase     <= rps_pkg::idle;
      screen    <= rps_pkg::scr_blank;
      outcome   <= rps_pkg::draw;
      score     <= '0;
      cycle_cnt <= '0;
      tick_cnt  <= '0;
    end else begin
      phase  <= phase_d;
      screen <= screen_d;
      if (round.start) begin
        outcome <= judged;
        if (judged == rps_pkg::win && score.user_wins != 3'(rps_pkg::LED_BITS))
          score.user_wins <= score.user_wins + 3'd1;
        if (judged == rps_pkg::lose && score.com_wins != 3'(rps_pkg::LED_BITS))
          score.com_wins <= score.com_wins + 3'd1;
      end
      if (round.start || !held) begin
        cycle_cnt <= '0;
        tick_cnt  <= '0;
      end else if (tick_wrap) begin
        cycle_cnt <= '0;
        tick_cnt  <= tick_next;
      end else if (timing) begin
        cycle_cnt <= cycle_cnt + CW'(1);
      end
    end
  end

endmodule

// ==== logic/rps_pkg.sv ====
package rps_pkg;

  localparam int NUM_COLS     = 10;
  localparam int ROW_BITS     = 14;
  localparam int LED_BITS     = 6;  // score saturates here too
  localparam int CHOICE_TICKS = 2;
  localparam int FINAL_TICK   = 6;

  typedef enum logic [1:0] {
    none     = 2'd0,
    rock     = 2'd1,
    scissors = 2'd2,
    paper    = 2'd3
  } choice_t;

  typedef enum logic [1:0] {
    draw = 2'd0,
    win  = 2'd1,
    lose = 2'd2
  } outcome_t;

  typedef enum logic [1:0] {
    idle        = 2'd0,
    show_choice = 2'd1,
    show_result = 2'd2,
    show_final  = 2'd3
  } phase_t;

  typedef enum logic [3:0] {
    scr_blank    = 4'd0,
    scr_rock     = 4'd1,
    scr_scissors = 4'd2,
    scr_paper    = 4'd3,
    scr_win      = 4'd4,
    scr_draw     = 4'd5,
    scr_lose     = 4'd6,
    scr_happy    = 4'd7,
    scr_sad      = 4'd8
  } screen_t;

  typedef struct packed {
    logic    start;  // one cycle
    choice_t user;
    choice_t com;
  } round_t;

  typedef struct packed {
    logic [2:0] user_wins;
    logic [2:0] com_wins;
  } score_t;

  // indexed by choice minus one, then by column
  localparam logic [ROW_BITS-1:0] glyph_rows [3][NUM_COLS] = '{
    '{14'b00000000000000, 14'b00000011111100, 14'b00000010000010, 14'b00000010000010,
      14'b00000010000010, 14'b00000010000010, 14'b00000010000010, 14'b00000011111100,
      14'b00000000000000, 14'b00000000000000},
    '{14'b00000000000000, 14'b00000011111100, 14'b00000010000010, 14'b00000010000010,
      14'b00000010000010, 14'b01111110000010, 14'b00000010000010, 14'b00111111111100,
      14'b00000000000000, 14'b00000000000000},
    '{14'b00000000000000, 14'b00111111111100, 14'b00000010000010, 14'b01111110000010,
      14'b00000010000010, 14'b01111110000010, 14'b00000010000010, 14'b00111111111100,
      14'b00000000100000, 14'b00000001000000}
  };

endpackage

// ==== logic/rps_top.sv ====
`timescale 1ns/1ps

module rps_top #(
  parameter int TICK_DIV   = 12500000,
  parameter int SCAN_DIV   = 9000,
  parameter int WIN_TARGET = 3
) (
  input  logic                          clk,
  input  logic                          DELAY,
  input  logic [2:0]                    keys,
  output rps_pkg::screen_t              screen,
  output rps_pkg::phase_t               phase,
  output rps_pkg::outcome_t             outcome,
  output logic [rps_pkg::LED_BITS-1:0]  user_leds,
  output logic [rps_pkg::LED_BITS-1:0]  com_leds,
  output logic [rps_pkg::NUM_COLS-1:0]  dot_col,
  output logic [rps_pkg::ROW_BITS-1:0]  dot_row
);

  rps_pkg::round_t round;
  rps_pkg::score_t score;
  logic            held;

  key_capture i_key_capture (
    .clk   (clk),
    .DELAY (DELAY),
    .keys  (keys),
    .round (round),
    .held  (held)
  );

  round_sequencer #(
    .TICK_DIV   (TICK_DIV),
    .WIN_TARGET (WIN_TARGET)
  ) i_round_sequencer (
    .clk     (clk),
    .DELAY   (DELAY),
    .round   (round),
    .held    (held),
    .phase   (phase),
    .outcome (outcome),
    .screen  (screen),
    .score   (score)
  );

  matrix_scan #(
    .SCAN_DIV (SCAN_DIV)
  ) i_matrix_scan (
    .clk       (clk),
    .DELAY     (DELAY),
    .screen    (screen),
    .score     (score),
    .dot_col   (dot_col),
    .dot_row   (dot_row),
    .user_leds (user_leds),
    .com_leds  (com_leds)
  );

endmodule

// ==== src.f ====
logic/rps_pkg.sv
logic/key_capture.sv
logic/round_sequencer.sv
logic/matrix_scan.sv
logic/rps_top.sv
verification/rps_assert.sv
verification/rps_tb.sv

// ==== verification/rps_assert.sv ====
`timescale 1ns/1ps

module rps_assert (
  input logic                         clk,
  input logic                         DELAY,
  input logic [rps_pkg::NUM_COLS-1:0] dot_col,
  input rps_pkg::round_t              round,
  input logic                         held,
  input rps_pkg::phase_t              phase
);

  int unsigned fails = 0;  // read by the testbench at the end

  col_onehot: assert property (@(posedge clk) disable iff (DELAY) $onehot(dot_col))
    else begin
      $error("dot_col is not one-hot");
      fails++;
    end

  start_single: assert property (@(posedge clk) disable iff (DELAY)
    round.start |=> !round.start)
    else begin
      $error("round.start high for two cycles");
      fails++;
    end

  // a pending start still wins over a release
  idle_on_release: assert property (@(posedge clk) disable iff (DELAY)
    (!held && !round.start) |=> phase == rps_pkg::idle)
    else begin
      $error("phase not idle after key release");
      fails++;
    end

endmodule

bind rps_top rps_assert i_rps_assert (
  .clk     (clk),
  .DELAY   (DELAY),
  .dot_col (dot_col),
  .round   (round),
  .held    (held),
  .phase   (phase)
);

// ==== verification/rps_tb.sv ====
`timescale 1ns/1ps

module rps_tb;

  localparam int TICK      = 8;
  localparam int RESULT_AT = 2 * TICK;  // two ticks of show_choice
  localparam int FINAL_AT  = 6 * TICK;
  localparam int SCAN      = 4;
  localparam int TARGET    = 3;
  localparam int ROUNDS    = 60;

  logic              clk = 1'b0;
  logic              DELAY;
  logic [2:0]        keys;
  rps_pkg::screen_t  screen;
  rps_pkg::phase_t   phase;
  rps_pkg::outcome_t outcome;
  logic [5:0]        user_leds;
  logic [5:0]        com_leds;
  logic [9:0]        dot_col;
  logic [13:0]       dot_row;

  rps_pkg::choice_t  m_pick;
  rps_pkg::choice_t  m_user;
  rps_pkg::choice_t  m_com;
  rps_pkg::phase_t   m_phase;
  rps_pkg::outcome_t m_outcome;
  logic [2:0]        m_keys_q;
  logic              m_start;  // model copy of round.start
  int                m_user_wins;
  int                m_com_wins;
  int                m_hold;
  int                m_div;
  int                m_col;

  int         errors = 0;
  int         checks = 0;
  bit         checking = 0;
  bit         timed_out = 0;
  int         gap;
  int         hold;
  int         r;
  logic [2:0] key;
  bit         ok;

  rps_top #(
    .TICK_DIV   (TICK),
    .SCAN_DIV   (SCAN),
    .WIN_TARGET (TARGET)
  ) i_rps_top (
    .clk       (clk),
    .DELAY     (DELAY),
    .keys      (keys),
    .screen    (screen),
    .phase     (phase),
    .outcome   (outcome),
    .user_leds (user_leds),
    .com_leds  (com_leds),
    .dot_col   (dot_col),
    .dot_row   (dot_row)
  );

  always #10 clk = ~clk;

  function automatic rps_pkg::outcome_t judge_round(rps_pkg::choice_t u, rps_pkg::choice_t c);
    rps_pkg::choice_t prey;
    case (u)
      rps_pkg::rock:     prey = rps_pkg::scissors;
      rps_pkg::scissors: prey = rps_pkg::paper;
      default:           prey = rps_pkg::rock;
    endcase
    if (u == c)
      return rps_pkg::draw;
    if (c == prey)
      return rps_pkg::win;
    return rps_pkg::lose;
  endfunction

  function automatic rps_pkg::choice_t next_pick(rps_pkg::choice_t p);
    case (p)
      rps_pkg::rock:     return rps_pkg::scissors;
      rps_pkg::scissors: return rps_pkg::paper;
      default:           return rps_pkg::rock;
    endcase
  endfunction

  function automatic rps_pkg::choice_t key_choice(logic [2:0] k);
    case (k)
      3'b001:  return rps_pkg::rock;
      3'b010:  return rps_pkg::scissors;
      default: return rps_pkg::paper;
    endcase
  endfunction

  function automatic rps_pkg::screen_t model_screen();
    case (m_phase)
      rps_pkg::show_choice: begin
        if (m_com == rps_pkg::rock) return rps_pkg::scr_rock;
        if (m_com == rps_pkg::scissors) return rps_pkg::scr_scissors;
        return rps_pkg::scr_paper;
      end
      rps_pkg::show_result: begin
        if (m_outcome == rps_pkg::win) return rps_pkg::scr_win;
        if (m_outcome == rps_pkg::lose) return rps_pkg::scr_lose;
        return rps_pkg::scr_draw;
      end
      rps_pkg::show_final: begin
        if (m_com_wins >= TARGET) return rps_pkg::scr_sad;
        if (m_user_wins >= TARGET) return rps_pkg::scr_happy;
        return rps_pkg::scr_blank;
      end
      default: return rps_pkg::scr_blank;
    endcase
  endfunction

  // dark unless a choice is shown
  function automatic logic [13:0] expected_row();
    case (model_screen())
      rps_pkg::scr_rock:     return rps_pkg::glyph_rows[0][4'(m_col)];
      rps_pkg::scr_scissors: return rps_pkg::glyph_rows[1][4'(m_col)];
      rps_pkg::scr_paper:    return rps_pkg::glyph_rows[2][4'(m_col)];
      default:               return 14'd0;
    endcase
  endfunction

  function automatic logic [5:0] bar_of(int n);
    return ~(6'h3f >> n);  // lit from the msb down
  endfunction

  task automatic report_mismatch(string name, int exp, int got);
    errors++;
    $display("FAIL t=%0t %s expected %0d got %0d", $time, name, exp, got);
  endtask

  always @(posedge clk) begin
    if (DELAY) begin
      m_pick      = rps_pkg::rock;
      m_user      = rps_pkg::none;
      m_com       = rps_pkg::none;
      m_phase     = rps_pkg::idle;
      m_outcome   = rps_pkg::draw;
      m_keys_q    = 3'b000;
      m_start     = 1'b0;
      m_user_wins = 0;
      m_com_wins  = 0;
      m_hold      = 0;
      m_div       = 0;
      m_col       = 0;
    end else begin
      m_div++;
      if (m_div == SCAN) begin
        m_div = 0;
        m_col = (m_col == 9) ? 0 : m_col + 1;
      end
      if (m_start) begin
        m_phase   = rps_pkg::show_choice;
        m_outcome = judge_round(m_user, m_com);
        m_hold    = 0;
        if (m_outcome == rps_pkg::win && m_user_wins < 6) m_user_wins++;
        if (m_outcome == rps_pkg::lose && m_com_wins < 6) m_com_wins++;
      end else if (keys == 3'b000) begin
        m_phase = rps_pkg::idle;
      end else if (m_phase == rps_pkg::show_choice || m_phase == rps_pkg::show_result) begin
        m_hold++;
        if (m_hold == RESULT_AT) m_phase = rps_pkg::show_result;
        else if (m_hold == FINAL_AT) m_phase = rps_pkg::show_final;
      end
      m_start = $onehot(keys) && (m_keys_q == 3'b000);
      if (m_start) begin
        m_user = key_choice(keys);
        m_com  = m_pick;  // pick as it stood at the press edge
      end
      if (keys == 3'b000) m_pick = next_pick(m_pick);
      m_keys_q = keys;
    end
  end

  always @(negedge clk) begin
    if (checking) begin
      checks++;
      if (phase !== m_phase) report_mismatch("phase", int'(m_phase), int'(phase));
      if (screen !== model_screen()) report_mismatch("screen", int'(model_screen()), int'(screen));
      if (outcome !== m_outcome) report_mismatch("outcome", int'(m_outcome), int'(outcome));
      if (user_leds !== bar_of(m_user_wins))
        report_mismatch("user_leds", int'(bar_of(m_user_wins)), int'(user_leds));
      if (com_leds !== bar_of(m_com_wins))
        report_mismatch("com_leds", int'(bar_of(m_com_wins)), int'(com_leds));
      if (dot_col !== (10'b1 << m_col)) report_mismatch("dot_col", int'(10'b1 << m_col), int'(dot_col));
      if (dot_row !== expected_row())
        report_mismatch("dot_row", int'(expected_row()), int'(dot_row));
    end
  end

  task automatic play_round(input logic [2:0] k, input int h, output bit done);
    int n;
    bit seen;
    n    = 0;
    seen = 0;
    done = 1;
    keys = k;
    while (n < h) begin
      @(negedge clk);
      n++;
      if (phase == rps_pkg::show_choice) seen = 1;
    end
    keys = 3'b000;
    n = 0;
    while (!seen && n < 4) begin  // short holds see show_choice after release
      @(negedge clk);
      n++;
      if (phase == rps_pkg::show_choice) seen = 1;
    end
    if (!seen) begin
      $display("timeout: show_choice never appeared after a key press");
      done = 0;
    end
    n = 0;
    while (phase != rps_pkg::idle && n < 4) begin
      @(negedge clk);
      n++;
    end
    if (phase != rps_pkg::idle) begin
      $display("timeout: phase did not return to idle after key release");
      done = 0;
    end
  endtask

  initial begin
    void'($urandom(39));
    DELAY = 1'b1;
    keys  = 3'b000;
    repeat (8) @(negedge clk);
    DELAY = 1'b0;
    if (screen !== rps_pkg::scr_blank) report_mismatch("screen", 0, int'(screen));
    if (phase !== rps_pkg::idle) report_mismatch("phase", 0, int'(phase));
    if (user_leds !== 6'd0) report_mismatch("user_leds", 0, int'(user_leds));
    if (com_leds !== 6'd0) report_mismatch("com_leds", 0, int'(com_leds));
    if (dot_col !== 10'b1) report_mismatch("dot_col", 1, int'(dot_col));
    checking = 1;
    for (r = 0; r < ROUNDS && !timed_out; r++) begin
      gap  = $urandom % 21;
      hold = 1 + $urandom % 70;
      key  = 3'b001 << ($urandom % 3);
      repeat (gap) @(negedge clk);
      play_round(key, hold, ok);
      if (!ok) timed_out = 1;
    end
    repeat (4) @(negedge clk);
    errors = errors + i_rps_top.i_rps_assert.fails;
    $display("rounds %0d, checks %0d, errors %0d", r, checks, errors);
    if (errors == 0 && !timed_out)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

endmodule
